/* project.f */
source/ddrc_pkg.sv
source/fifo_cross_clocks.sv
source/ddrc_delay_bank.sv
source/ddrc_control.sv
source/ddrc_ctrl_top.sv
verif/ddrc_ctrl_checker.sv
verif/tb_ddrc_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the result.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ddrc_ctrl -f project.f \
    --Mdir obj_dir -o tb_ddrc_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ddrc_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "no result found in $LOG"
    exit 1
fi
exit 0

/* verif/tb_ddrc_ctrl.sv */
// Testbench for the DDR control register front end.
// Sends single writes and short bursts into ddrc_ctrl_top, predicts the
// register state with ddrc_ref_apply and hands the prediction to the checker.
// The run is bounded by a clk cycle counter.
`timescale 1ns/1ps

module tb_ddrc_ctrl;
    localparam int          NUM_DLY    = 16;
    localparam int          MAX_CYCLES = 3000;      // ~80 writes at up to 30 cycles, plus margin
    localparam int          QUIET      = 12;
    localparam logic [31:0] SEED       = 32'h7e62_995a;
    localparam logic [11:0] WIN_MASK   = 12'h400;   // 0x1400 cut to the 12 bit bus
    localparam logic [9:0]  PAT_OFF    = 10'h020;
    localparam logic [9:0]  PAGES_OFF  = 10'h021;
    localparam logic [9:0]  CMDA_OFF   = 10'h022;   // lines floated
    localparam logic [9:0]  CMDA_ON    = 10'h023;   // lines driven
    localparam logic [9:0]  EXTRA_OFF  = 10'h024;
    localparam logic [9:0]  DSET_OFF   = 10'h070;

    typedef struct packed {
        logic [7:0]              dqs;
        logic [7:0]              dqm;
        logic [7:0]              pages;             // {port1, port1_int, port0, port0_int}
        logic                    cmda_tri;
        logic                    inv_clk_div;
        logic [NUM_DLY-1:0][7:0] shadow;
        logic [NUM_DLY-1:0][7:0] active;
    } model_t;

    logic                 clk, phy_clk, mclk;
    logic [11:0]          pre_waddr, waddr;
    logic                 start_wburst, wr_en;
    logic [31:0]          wdata;
    logic                 busy, run_seq, dly_set, cmda_tri, inv_clk_div;
    logic [10:0]          run_addr;
    logic [3:0]           run_chn;
    logic [NUM_DLY*8-1:0] dly_active;
    logic [7:0]           dqs_pattern, dqm_pattern;
    logic [1:0]           port0_page, port0_int_page, port1_page, port1_int_page;
    logic                 check_req;
    logic                 burst_sel;                // current burst reaches the decoder
    model_t               model;
    int                   errors;
    int                   cycles = 0;

    always #20 clk = ~clk;
    always #14 phy_clk = ~phy_clk;                  // unrelated to clk

    ddrc_ctrl_top UUT (
        .clk(clk), .phy_clk(phy_clk), .mclk(mclk),
        .pre_waddr(pre_waddr), .start_wburst(start_wburst),
        .waddr(waddr), .wr_en(wr_en), .wdata(wdata), .busy(busy),
        .run_addr(run_addr), .run_chn(run_chn), .run_seq(run_seq),
        .dly_set(dly_set), .dly_active(dly_active),
        .dqs_pattern(dqs_pattern), .dqm_pattern(dqm_pattern),
        .port0_page(port0_page), .port0_int_page(port0_int_page),
        .port1_page(port1_page), .port1_int_page(port1_int_page),
        .cmda_tri(cmda_tri), .inv_clk_div(inv_clk_div)
    );

    ddrc_ctrl_checker #(.NUM_DLY(NUM_DLY)) check_i (
        .clk(clk), .phy_clk(phy_clk), .mclk(mclk),
        .pre_waddr(pre_waddr), .start_wburst(start_wburst),
        .waddr(waddr), .wr_en(wr_en), .wdata(wdata), .busy(busy),
        .run_seq(run_seq), .run_addr(run_addr), .run_chn(run_chn),
        .dly_set(dly_set), .dly_active(dly_active),
        .dqs_pattern(dqs_pattern), .dqm_pattern(dqm_pattern),
        .pages({port1_page, port1_int_page, port0_page, port0_int_page}),
        .cmda_tri(cmda_tri), .inv_clk_div(inv_clk_div), .check_req(check_req),
        .exp_dqs(model.dqs), .exp_dqm(model.dqm), .exp_pages(model.pages),
        .exp_cmda_tri(model.cmda_tri), .exp_inv_clk_div(model.inv_clk_div),
        .exp_active(model.active), .errors(errors)
    );

    // next register state after one decoded write; bit 11 is not decoded
    function automatic model_t ddrc_ref_apply(input logic [11:0] addr,
                                              input logic [31:0] data,
                                              input model_t      cur);
        model_t               nxt;
        ddrc_pkg::ctrl_word_u w;
        logic [9:0]           off;
        nxt = cur;
        w   = data;
        off = addr[9:0];
        if ((addr & WIN_MASK) == 12'h000) begin
            if (off == PAT_OFF) begin
                nxt.dqs = w.patterns.dqs;
                nxt.dqm = w.patterns.dqm;
            end else if (off == PAGES_OFF) begin
                nxt.pages = {w.pages.port1_page, w.pages.port1_int_page,
                             w.pages.port0_page, w.pages.port0_int_page};
            end else if (off == CMDA_OFF || off == CMDA_ON) begin
                nxt.cmda_tri = (off == CMDA_OFF);
            end else if (off == EXTRA_OFF) begin
                nxt.inv_clk_div = w.extra.inv_clk_div;
            end else if (off == DSET_OFF) begin
                nxt.active = cur.shadow;                    // all taps at once
            end else if (off[9:7] == 3'b001 && off[6:0] < NUM_DLY) begin
                nxt.shadow[off[3:0]] = w.delay.value;       // higher slots are ignored
            end
        end
        return nxt;
    endfunction

    // random target register, sometimes with the undecoded bit 11 set
    function automatic logic [11:0] rand_reg(input logic [31:0] r);
        logic [11:0] a;
        case (r[2:0])
            3'd0:    a = {8'h00, r[7:4]};                   // run channel
            3'd1:    a = 12'h020;
            3'd2:    a = 12'h021;
            3'd3:    a = {11'h011, r[8]};                   // cmda on or off
            3'd4:    a = 12'h024;
            3'd7:    a = 12'h070;
            default: a = {5'b00001, 2'b00, r[12:8]};        // delay slot 0..31
        endcase
        return a | {r[13], 11'h000};
    endfunction

    task automatic start_burst(input logic [11:0] pre);
        @(posedge clk);
        #2;
        wr_en        = 1'b0;
        start_wburst = 1'b1;
        pre_waddr    = pre;
        burst_sel    = (pre & WIN_MASK) == 12'h000;
    endtask

    task automatic burst_write(input logic [11:0] a, input logic [31:0] d);
        @(posedge clk);
        #2;
        start_wburst = 1'b0;
        wr_en        = 1'b1;
        waddr        = a;
        wdata        = d;
        if (burst_sel) model = ddrc_ref_apply(a, d, model);
    endtask

    task automatic end_burst();
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic single_write(input logic [11:0] a, input logic [31:0] d);
        start_burst(a);
        burst_write(a, d);
        end_burst();
    endtask

    task automatic quiet_check();
        repeat (QUIET) @(posedge clk);
        #2;
        check_req = 1'b1;
        @(posedge clk);
        #2;
        check_req = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d clk cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int n;
        void'($urandom(SEED));
        clk          = 1'b0;
        phy_clk      = 1'b0;
        mclk         = 1'b1;
        pre_waddr    = '0;
        start_wburst = 1'b0;
        waddr        = '0;
        wr_en        = 1'b0;
        wdata        = '0;
        check_req    = 1'b0;
        burst_sel    = 1'b0;
        model          = '0;
        model.dqs      = 8'h55;
        model.cmda_tri = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        mclk = 1'b0;
        quiet_check();                                      // reset values, busy idle

        single_write(12'h020, $urandom);
        single_write(12'h021, $urandom);
        single_write(12'h024, 32'h1);
        single_write(12'h023, $urandom);
        quiet_check();
        single_write(12'h022, $urandom);
        single_write(12'h024, 32'h0);
        quiet_check();

        for (int i = 0; i < 4; i++) single_write({8'h00, 4'($urandom)}, $urandom);
        quiet_check();

        for (int i = 0; i < 10; i++) single_write({7'b0000100, 5'($urandom)}, $urandom);
        quiet_check();                                      // shadow only, taps unchanged
        single_write(12'h070, $urandom);
        quiet_check();

        single_write(12'h420, $urandom);                    // outside the window
        single_write(12'hc03, $urandom);
        start_burst(12'h010);                               // window burst, stray addresses
        burst_write(12'h420, $urandom);
        burst_write(12'h405, $urandom);
        burst_write(12'h470, $urandom);
        end_burst();
        start_burst(12'h4f0);                               // in-window writes, wrong burst
        burst_write(12'h020, $urandom);
        burst_write(12'h005, $urandom);
        burst_write(12'h070, $urandom);
        end_burst();
        quiet_check();

        for (int b = 0; b < 20; b++) begin
            n = 1 + int'($urandom % 4);
            start_burst(12'($urandom));
            for (int k = 0; k < n; k++) burst_write(rand_reg($urandom), $urandom);
            end_burst();
        end
        quiet_check();

        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verif/ddrc_ctrl_checker.sv */
// Checker for the DDR control register front end.
// Queues bus writes that land in the control window, matches run_seq and
// dly_set pulses against that queue in order, and compares the level outputs
// with the expected values from the testbench when check_req is high.
`timescale 1ns/1ps

module ddrc_ctrl_checker #(
    parameter int NUM_DLY = 16
) (
    input  logic                   clk,
    input  logic                   phy_clk,
    input  logic                   mclk,
    input  logic [11:0]            pre_waddr,
    input  logic                   start_wburst,
    input  logic [11:0]            waddr,
    input  logic                   wr_en,
    input  logic [31:0]            wdata,
    input  logic                   busy,
    input  logic                   run_seq,
    input  logic [10:0]            run_addr,
    input  logic [3:0]             run_chn,
    input  logic                   dly_set,
    input  logic [NUM_DLY*8-1:0]   dly_active,
    input  logic [7:0]             dqs_pattern,
    input  logic [7:0]             dqm_pattern,
    input  logic [7:0]             pages,        // {port1, port1_int, port0, port0_int}
    input  logic                   cmda_tri,
    input  logic                   inv_clk_div,
    input  logic                   check_req,    // bus is quiet, compare levels
    input  logic [7:0]             exp_dqs,
    input  logic [7:0]             exp_dqm,
    input  logic [7:0]             exp_pages,
    input  logic                   exp_cmda_tri,
    input  logic                   exp_inv_clk_div,
    input  logic [NUM_DLY*8-1:0]   exp_active,
    output int                     errors
);
    logic        in_burst;     // burst started inside the control window
    logic        busy_burst;   // burst started inside the busy window
    logic [43:0] wq[$];        // {waddr, wdata} in bus order
    int          bus_errs = 0;
    int          phy_errs = 0;

    assign errors = bus_errs + phy_errs;

    function automatic void fail_line(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
    endfunction

    function automatic logic win_hit(input logic [11:0] a);
        return (a & 12'h400) == 12'h000;    // bit 12 of 0x1400 is past the bus width
    endfunction

    function automatic logic busy_hit(input logic [11:0] a);
        return (a & 12'hc00) == 12'h800;
    endfunction

    // 1 run, 2 delay set, 0 no strobe
    function automatic logic [1:0] strobe_kind(input logic [11:0] a);
        if (!win_hit(a)) return 2'd0;
        if (a[9:4] == 6'h00) return 2'd1;
        if (a[9:0] == 10'h070) return 2'd2;
        return 2'd0;
    endfunction

    always @(posedge clk) begin
        if (mclk) begin
            in_burst   <= 1'b0;
            busy_burst <= 1'b0;
        end else begin
            if (busy && !(start_wburst ? busy_hit(pre_waddr) : busy_burst)) begin
                fail_line($sformatf("busy high for burst at %h", pre_waddr));
                bus_errs++;
            end
            if (start_wburst) begin
                in_burst   <= win_hit(pre_waddr);
                busy_burst <= busy_hit(pre_waddr);
            end
            if (wr_en && in_burst) wq.push_back({waddr, wdata});
            if (check_req) begin
                if (dqs_pattern !== exp_dqs || dqm_pattern !== exp_dqm) begin
                    fail_line($sformatf("dqs %h dqm %h, expected %h %h",
                                        dqs_pattern, dqm_pattern, exp_dqs, exp_dqm));
                    bus_errs++;
                end
                if (pages !== exp_pages) begin
                    fail_line($sformatf("pages %h, expected %h", pages, exp_pages));
                    bus_errs++;
                end
                if (cmda_tri !== exp_cmda_tri || inv_clk_div !== exp_inv_clk_div) begin
                    fail_line($sformatf("cmda_tri %b inv_clk_div %b, expected %b %b",
                                        cmda_tri, inv_clk_div, exp_cmda_tri, exp_inv_clk_div));
                    bus_errs++;
                end
                if (dly_active !== exp_active) begin
                    fail_line($sformatf("dly_active %h, expected %h", dly_active, exp_active));
                    bus_errs++;
                end
                foreach (wq[i]) begin
                    if (strobe_kind(wq[i][43:32]) != 2'd0) begin
                        $display("error: no strobe seen for write to %h by t=%0t",
                                 wq[i][43:32], $time);
                        bus_errs++;
                    end
                end
                wq.delete();                 // everything has drained by now
            end
        end
    end

    always @(posedge phy_clk) begin : strobe_check
        logic [43:0] e;
        logic [1:0]  kind;
        e    = '0;
        kind = 2'd0;
        if (!mclk && (run_seq || dly_set)) begin
            while (wq.size() > 0 && kind == 2'd0) begin
                e    = wq.pop_front();       // level writes go by without a strobe
                kind = strobe_kind(e[43:32]);
            end
            if (kind == 2'd0) begin
                $display("error: unexpected strobe at t=%0t, no write pending", $time);
                phy_errs++;
            end else if ((kind == 2'd1) != run_seq) begin
                $display("error: wrong strobe at t=%0t for write to %h", $time, e[43:32]);
                phy_errs++;
            end else if (run_seq && (run_chn !== e[35:32] || run_addr !== e[10:0])) begin
                fail_line($sformatf("run chn %h addr %h, expected %h %h",
                                    run_chn, run_addr, e[35:32], e[10:0]));
                phy_errs++;
            end
        end
    end

endmodule

/* source/ddrc_ctrl_top.sv */
// Top of the control register front end. Connects the register decode to
// the delay bank and sets the address windows and the number of delays.
// Bus writes arrive on clk, all outputs are on phy_clk except busy.
`timescale 1ns/1ps

module ddrc_ctrl_top #(
    parameter int ADDR_BITS         = 12,
    parameter int CONTROL_ADDR      = 'h1000, // control register window
    parameter int CONTROL_ADDR_MASK = 'h1400,
    parameter int BUSY_WR_ADDR      = 'h1800, // bursts here may see busy
    parameter int BUSY_WR_ADDR_MASK = 'h1c00,
    parameter int NUM_DLY           = 16
) (
    input  logic                                   clk,
    input  logic                                   phy_clk,
    input  logic                                   mclk,
    input  logic [ADDR_BITS-1:0]                   pre_waddr,
    input  logic                                   start_wburst,
    input  logic [ADDR_BITS-1:0]                   waddr,
    input  logic                                   wr_en,
    input  logic [ddrc_pkg::DATA_BITS-1:0]         wdata,
    output logic                                   busy,
    output logic [ddrc_pkg::RUN_ADDR_BITS-1:0]     run_addr,
    output logic [3:0]                             run_chn,
    output logic                                   run_seq,
    output logic                                   dly_set,
    output logic [NUM_DLY*ddrc_pkg::DLY_BITS-1:0]  dly_active,
    output logic [7:0]                             dqs_pattern,
    output logic [7:0]                             dqm_pattern,
    output logic [1:0]                             port0_page,
    output logic [1:0]                             port0_int_page,
    output logic [1:0]                             port1_page,
    output logic [1:0]                             port1_int_page,
    output logic                                   cmda_tri,
    output logic                                   inv_clk_div
);
    logic                                ld_delay;
    logic [ddrc_pkg::DLY_ADDR_BITS-1:0]  dly_addr;
    logic [ddrc_pkg::DLY_BITS-1:0]       dly_data;

    ddrc_control #(
        .ADDR_BITS         (ADDR_BITS),
        .CONTROL_ADDR      (CONTROL_ADDR),
        .CONTROL_ADDR_MASK (CONTROL_ADDR_MASK),
        .BUSY_WR_ADDR      (BUSY_WR_ADDR),
        .BUSY_WR_ADDR_MASK (BUSY_WR_ADDR_MASK)
    ) control_i (
        .clk            (clk),
        .phy_clk        (phy_clk),
        .mclk           (mclk),
        .pre_waddr      (pre_waddr),
        .start_wburst   (start_wburst),
        .waddr          (waddr),
        .wr_en          (wr_en),
        .wdata          (wdata),
        .busy           (busy),
        .run_addr       (run_addr),
        .run_chn        (run_chn),
        .run_seq        (run_seq),
        .dly_data       (dly_data),
        .dly_addr       (dly_addr),
        .ld_delay       (ld_delay),
        .dly_set        (dly_set),
        .cmda_tri       (cmda_tri),
        .inv_clk_div    (inv_clk_div),
        .dqs_pattern    (dqs_pattern),
        .dqm_pattern    (dqm_pattern),
        .port0_page     (port0_page),
        .port0_int_page (port0_int_page),
        .port1_page     (port1_page),
        .port1_int_page (port1_int_page)
    );

    ddrc_delay_bank #(
        .NUM_DLY    (NUM_DLY)
    ) delay_bank_i (
        .phy_clk    (phy_clk),
        .mclk       (mclk),
        .ld_delay   (ld_delay),
        .dly_addr   (dly_addr),
        .dly_data   (dly_data),
        .dly_set    (dly_set),
        .dly_active (dly_active)
    );

endmodule

/* source/ddrc_control.sv */
// Control register decode of the DDR controller front end.
// On clk it picks bursts aimed at the control window, raises busy while the
// crossing FIFO fills, and pushes {waddr, wdata}. On phy_clk it pops one entry
// per cycle and turns it into single-cycle strobes and level registers.
`timescale 1ns/1ps

module ddrc_control #(
    parameter int ADDR_BITS         = 12,
    parameter int CONTROL_ADDR      = 'h1000,
    parameter int CONTROL_ADDR_MASK = 'h1400,
    parameter int BUSY_WR_ADDR      = 'h1800,
    parameter int BUSY_WR_ADDR_MASK = 'h1c00
) (
    input  logic                                clk,
    input  logic                                phy_clk,
    input  logic                                mclk,
    input  logic [ADDR_BITS-1:0]                pre_waddr,    // valid with start_wburst
    input  logic                                start_wburst,
    input  logic [ADDR_BITS-1:0]                waddr,
    input  logic                                wr_en,
    input  logic [ddrc_pkg::DATA_BITS-1:0]      wdata,
    output logic                                busy,         // combinational on start_wburst
    output logic [ddrc_pkg::RUN_ADDR_BITS-1:0]  run_addr,
    output logic [3:0]                          run_chn,      // low address bits of run write
    output logic                                run_seq,
    output logic [ddrc_pkg::DLY_BITS-1:0]       dly_data,
    output logic [ddrc_pkg::DLY_ADDR_BITS-1:0]  dly_addr,
    output logic                                ld_delay,
    output logic                                dly_set,
    output logic                                cmda_tri,     // 1 floats command/address lines
    output logic                                inv_clk_div,
    output logic [7:0]                          dqs_pattern,
    output logic [7:0]                          dqm_pattern,
    output logic [1:0]                          port0_page,
    output logic [1:0]                          port0_int_page,
    output logic [1:0]                          port1_page,
    output logic [1:0]                          port1_int_page
);
    localparam int FIFO_DEPTH_BITS = 4;
    localparam int FIFO_WIDTH      = ADDR_BITS + ddrc_pkg::DATA_BITS;

    // window bits above the port width fall away here
    localparam logic [ADDR_BITS-1:0] WIN_A  = ADDR_BITS'(CONTROL_ADDR);
    localparam logic [ADDR_BITS-1:0] WIN_M  = ADDR_BITS'(CONTROL_ADDR_MASK);
    localparam logic [ADDR_BITS-1:0] BUSY_A = ADDR_BITS'(BUSY_WR_ADDR);
    localparam logic [ADDR_BITS-1:0] BUSY_M = ADDR_BITS'(BUSY_WR_ADDR_MASK);

    // offsets inside the control window
    localparam logic [ADDR_BITS-1:0] EXACT_M    = 'h3ff;
    localparam logic [ADDR_BITS-1:0] RUN_REL    = 'h000; // 16 channels
    localparam logic [ADDR_BITS-1:0] RUN_REL_M  = 'h3f0;
    localparam logic [ADDR_BITS-1:0] PAT_REL    = 'h020;
    localparam logic [ADDR_BITS-1:0] PAGES_REL  = 'h021;
    localparam logic [ADDR_BITS-1:0] CMDA_REL   = 'h022; // 0x022 off, 0x023 on
    localparam logic [ADDR_BITS-1:0] CMDA_REL_M = 'h3fe;
    localparam logic [ADDR_BITS-1:0] EXTRA_REL  = 'h024;
    localparam logic [ADDR_BITS-1:0] DSET_REL   = 'h070;
    localparam logic [ADDR_BITS-1:0] DLD_REL    = 'h080; // 128 delay slots
    localparam logic [ADDR_BITS-1:0] DLD_REL_M  = 'h380;

    logic                                   selected;      // burst hits control window
    logic                                   selected_busy; // burst hits busy window
    logic                                   busy_r;
    logic                                   pre_busy_hit;
    logic                                   fifo_half_empty;
    logic                                   fifo_nempty;
    logic                                   fifo_re;
    logic [FIFO_WIDTH-1:0]                  fifo_dout;
    logic [ADDR_BITS-1:0]                   fifo_addr;
    ddrc_pkg::ctrl_word_u                   fifo_word;
    logic [ddrc_pkg::DLY_ADDR_BITS-1:0]     addr_r;        // held with the strobes
    ddrc_pkg::ctrl_word_u                   word_r;

    function automatic logic reg_hit(input logic [ADDR_BITS-1:0] a,
                                     input logic [ADDR_BITS-1:0] rel,
                                     input logic [ADDR_BITS-1:0] rel_m);
        return ((a ^ (WIN_A | rel)) & (WIN_M | rel_m)) == '0;
    endfunction

    assign pre_busy_hit = ((pre_waddr ^ BUSY_A) & BUSY_M) == '0;

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            selected      <= 1'b0;
            selected_busy <= 1'b0;
            busy_r        <= 1'b0;
        end else begin
            if (start_wburst) begin
                selected      <= ((pre_waddr ^ WIN_A) & WIN_M) == '0;
                selected_busy <= pre_busy_hit;
            end
            busy_r <= !fifo_half_empty;
        end
    end

    assign busy = busy_r && (start_wburst ? pre_busy_hit : selected_busy);

    fifo_cross_clocks #(
        .DATA_WIDTH (FIFO_WIDTH),
        .DATA_DEPTH (FIFO_DEPTH_BITS)
    ) fifo_i (
        .mclk       (mclk),
        .clk        (clk),
        .phy_clk    (phy_clk),
        .we         (wr_en && selected),
        .re         (fifo_re),
        .data_in    ({waddr, wdata}),
        .data_out   (fifo_dout),
        .nempty     (fifo_nempty),
        .half_empty (fifo_half_empty)
    );

    assign fifo_re   = fifo_nempty; // drain one entry per phy_clk
    assign fifo_addr = fifo_dout[FIFO_WIDTH-1:ddrc_pkg::DATA_BITS];
    assign fifo_word = fifo_dout[ddrc_pkg::DATA_BITS-1:0];

    always_ff @(posedge phy_clk or posedge mclk) begin
        if (mclk) begin
            run_seq        <= 1'b0;
            ld_delay       <= 1'b0;
            dly_set        <= 1'b0;
            dqs_pattern    <= 8'h55;
            dqm_pattern    <= 8'h00;
            port1_page     <= 2'b0;
            port1_int_page <= 2'b0;
            port0_page     <= 2'b0;
            port0_int_page <= 2'b0;
            cmda_tri       <= 1'b1;
            inv_clk_div    <= 1'b0;
        end else begin
            run_seq  <= fifo_re && reg_hit(fifo_addr, RUN_REL, RUN_REL_M);
            ld_delay <= fifo_re && reg_hit(fifo_addr, DLD_REL, DLD_REL_M);
            dly_set  <= fifo_re && reg_hit(fifo_addr, DSET_REL, EXACT_M);
            if (fifo_re && reg_hit(fifo_addr, PAT_REL, EXACT_M)) begin
                dqs_pattern <= fifo_word.patterns.dqs;
                dqm_pattern <= fifo_word.patterns.dqm;
            end
            if (fifo_re && reg_hit(fifo_addr, PAGES_REL, EXACT_M)) begin
                port1_page     <= fifo_word.pages.port1_page;
                port1_int_page <= fifo_word.pages.port1_int_page;
                port0_page     <= fifo_word.pages.port0_page;
                port0_int_page <= fifo_word.pages.port0_int_page;
            end
            if (fifo_re && reg_hit(fifo_addr, CMDA_REL, CMDA_REL_M))
                cmda_tri <= ~fifo_addr[0]; // address bit 0 enables the lines
            if (fifo_re && reg_hit(fifo_addr, EXTRA_REL, EXACT_M))
                inv_clk_div <= fifo_word.extra.inv_clk_div;
        end
    end

    always_ff @(posedge phy_clk) begin
        if (fifo_re) begin
            addr_r <= fifo_addr[ddrc_pkg::DLY_ADDR_BITS-1:0];
            word_r <= fifo_word;
        end
    end

    assign run_chn  = addr_r[3:0];
    assign dly_addr = addr_r;
    assign run_addr = word_r.run.run_addr;
    assign dly_data = word_r.delay.value;

    // offset ranges must stay disjoint, one strobe per decoded write
    a_one_strobe: assert property (@(posedge phy_clk) disable iff (mclk)
        $onehot0({run_seq, ld_delay, dly_set}))
        else $error("ddrc_control: more than one strobe in a cycle");

endmodule

/* source/ddrc_delay_bank.sv */
// Delay register bank for the IDELAY/ODELAY taps.
// ld_delay fills one shadow entry, dly_set moves the whole shadow set into
// the active outputs on one phy_clk edge so all taps change together.
`timescale 1ns/1ps

module ddrc_delay_bank #(
    parameter int NUM_DLY = 16
) (
    input  logic                                   phy_clk,
    input  logic                                   mclk,
    input  logic                                   ld_delay,
    input  logic [ddrc_pkg::DLY_ADDR_BITS-1:0]     dly_addr,
    input  logic [ddrc_pkg::DLY_BITS-1:0]          dly_data,
    input  logic                                   dly_set,
    output logic [NUM_DLY*ddrc_pkg::DLY_BITS-1:0]  dly_active // entry i at bits i*DLY_BITS
);
    logic [NUM_DLY-1:0][ddrc_pkg::DLY_BITS-1:0] shadow;

    always_ff @(posedge phy_clk or posedge mclk) begin
        if (mclk) begin
            shadow <= '0;
        end else if (ld_delay && (32'(dly_addr) < NUM_DLY)) begin
            shadow[dly_addr] <= dly_data; // slots past NUM_DLY belong to other banks
        end
    end

    always_ff @(posedge phy_clk or posedge mclk) begin
        if (mclk) dly_active <= '0;
        else if (dly_set) dly_active <= shadow;
    end

    // taps only move on the cycle after dly_set
    a_apply_only: assert property (@(posedge phy_clk) disable iff (mclk)
        !$stable(dly_active) |-> $past(dly_set))
        else $error("ddrc_delay_bank: active delays changed without dly_set");

endmodule

/* source/fifo_cross_clocks.sv */
// Small asynchronous FIFO carrying control writes from clk to phy_clk.
// Gray pointers cross through two flops each way. data_out shows the head
// entry while nempty is high, re pops it. half_empty is on the write side
// and lets the bus side throttle bursts before the FIFO fills.
`timescale 1ns/1ps

module fifo_cross_clocks #(
    parameter int DATA_WIDTH = 16,
    parameter int DATA_DEPTH = 4      // log2 of the entry count
) (
    input  logic                  mclk,
    input  logic                  clk,       // write side
    input  logic                  phy_clk,   // read side
    input  logic                  we,
    input  logic                  re,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  nempty,    // phy_clk domain
    output logic                  half_empty // clk domain
);
    localparam int ENTRIES = 1 << DATA_DEPTH;

    logic [DATA_WIDTH-1:0] mem [ENTRIES];
    logic [DATA_DEPTH:0]   wr_bin;
    logic [DATA_DEPTH:0]   wr_gray;
    logic [DATA_DEPTH:0]   wr_bin_nxt;
    logic [DATA_DEPTH:0]   rd_bin;
    logic [DATA_DEPTH:0]   rd_gray;
    logic [DATA_DEPTH:0]   rd_bin_nxt;
    logic [DATA_DEPTH:0]   wr_gray_s1; // write pointer seen on phy_clk
    logic [DATA_DEPTH:0]   wr_gray_s2;
    logic [DATA_DEPTH:0]   rd_gray_s1; // read pointer seen on clk
    logic [DATA_DEPTH:0]   rd_gray_s2;
    logic [DATA_DEPTH:0]   used;       // write side fill, pessimistic

    function automatic logic [DATA_DEPTH:0] gray2bin(input logic [DATA_DEPTH:0] g);
        logic [DATA_DEPTH:0] b;
        b[DATA_DEPTH] = g[DATA_DEPTH];
        for (int i = DATA_DEPTH - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    assign wr_bin_nxt = wr_bin + 1'b1;
    assign rd_bin_nxt = rd_bin + 1'b1;

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (we) begin
                wr_bin  <= wr_bin_nxt;
                wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) mem[wr_bin[DATA_DEPTH-1:0]] <= data_in;
    end

    assign used       = wr_bin - gray2bin(rd_gray_s2);
    assign half_empty = ~|used[DATA_DEPTH:DATA_DEPTH-1]; // fewer than ENTRIES/2 in use

    always_ff @(posedge phy_clk or posedge mclk) begin
        if (mclk) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (re && nempty) begin
                rd_bin  <= rd_bin_nxt;
                rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            end
        end
    end

    assign nempty   = rd_gray != wr_gray_s2;
    assign data_out = mem[rd_bin[DATA_DEPTH-1:0]]; // head entry, fall-through

    // the bus side must honour busy, so the FIFO never sees a write when full
    a_no_overflow: assert property (@(posedge clk) disable iff (mclk) we |-> !used[DATA_DEPTH])
        else $error("fifo_cross_clocks: write into full FIFO");

endmodule

/* source/ddrc_pkg.sv */
// Shared widths and the control data word layout for the DDR controller
// register front end. Modules refer to these by ddrc_pkg::name.
// ctrl_word_u gives each register its own view of one bus data word.
package ddrc_pkg;

    localparam int DATA_BITS     = 32; // system bus data width
    localparam int DLY_BITS      = 8;  // one delay tap value
    localparam int DLY_ADDR_BITS = 7;  // delay register select
    localparam int RUN_ADDR_BITS = 11; // sequencer start address

    typedef struct packed {
        logic [DATA_BITS-17:0] unused;
        logic [7:0]            dqm;  // dqm pattern, normally 0
        logic [7:0]            dqs;  // dqs pattern, normally 0x55
    } patterns_t;

    typedef struct packed {
        logic [DATA_BITS-9:0] unused;
        logic [1:0]           port1_page;
        logic [1:0]           port1_int_page;
        logic [1:0]           port0_page;
        logic [1:0]           port0_int_page;
    } pages_t;

    typedef struct packed {
        logic [DATA_BITS-RUN_ADDR_BITS-1:0] unused;
        logic [RUN_ADDR_BITS-1:0]           run_addr; // msb set selects auto mode
    } run_t;

    typedef struct packed {
        logic [DATA_BITS-DLY_BITS-1:0] unused;
        logic [DLY_BITS-1:0]           value;
    } delay_t;

    typedef struct packed {
        logic [DATA_BITS-2:0] unused;
        logic                 inv_clk_div;
    } extra_t;

    // view chosen by the register offset of the write
    typedef union packed {
        patterns_t patterns;
        pages_t    pages;
        run_t      run;
        delay_t    delay;
        extra_t    extra;
    } ctrl_word_u;

endpackage
